//--- rtl/wb_soc_pkg.sv
// Bus widths, address map and types shared by every block of the memory subsystem and its testbench
package wb_soc_pkg;

    // Bus geometry
    localparam int BUS_ADDR_WIDTH = 10;              // Word address
    localparam int BUS_DATA_WIDTH = 32;
    localparam int BUS_SEL_WIDTH  = 4;               // One bit per byte lane

    // RAM geometry
    localparam int RAM_ADDR_WIDTH = 8;
    localparam int RAM_DEPTH      = 2 ** RAM_ADDR_WIDTH;  // 256 words
    localparam bit CLEAR_RAM_ON_RESET = 1'b1;        // Zero the array while RESET_MEM is high

    localparam int GPIO_WIDTH = 32;

    // Address map
    localparam int REGION_BIT    = BUS_ADDR_WIDTH - 1;  // 0 selects RAM, 1 selects GPIO
    localparam int GPIO_REG_BITS = 2;                   // Register index in the low bits

    typedef logic [BUS_ADDR_WIDTH-1:0] bus_adr_t;
    typedef logic [BUS_DATA_WIDTH-1:0] bus_dat_t;
    typedef logic [BUS_SEL_WIDTH-1:0]  bus_sel_t;
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_adr_t;
    typedef logic [GPIO_WIDTH-1:0]     gpio_t;
    typedef logic [GPIO_REG_BITS-1:0]  gpio_reg_t;

    // GPIO register indices, index 3 left unmapped
    localparam gpio_reg_t GPIO_REG_OUT    = 2'd0;
    localparam gpio_reg_t GPIO_REG_IN     = 2'd1;
    localparam gpio_reg_t GPIO_REG_TOGGLE = 2'd2;

    // Widen a byte select into a bit mask over the data word
    function automatic bus_dat_t sel_to_mask(input bus_sel_t sel);
        bus_dat_t mask;
        for (int lane = 0; lane < BUS_SEL_WIDTH; lane++) begin
            mask[lane*8 +: 8] = {8{sel[lane]}};
        end
        return mask;
    endfunction

endpackage

//--- rtl/wb_if.sv
// Wishbone single-cycle link from the address decoder to one slave, instantiated once per slave
interface wb_if
    import wb_soc_pkg::*;
();

    // Request, driven by the master
    logic     cyc;
    logic     stb;
    logic     we;
    bus_sel_t sel;
    bus_adr_t adr;
    bus_dat_t dat_w;

    // Response, driven by the slave
    bus_dat_t dat_r;   // Zero unless a read is answered
    logic     ack;     // One-cycle pulse
    logic     err;

    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack,
        input  err
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack,
        output err
    );

endinterface

//--- rtl/ram_wb.sv
// Byte-selectable word RAM on a Wishbone slave port, answers every request after one clock
module ram_wb
    import wb_soc_pkg::*;
(
    input  logic clk_i,
    input  logic RESET_MEM,   // Synchronous, active high
    wb_if.slave  bus
);

    bus_dat_t mem [RAM_DEPTH];   // Storage array

    ram_adr_t idx;               // Word index from low address bits
    bus_dat_t lane_mask;         // Byte select as bit mask
    logic     req;               // Valid strobe this cycle
    logic     ack_q;
    bus_dat_t dat_q;

    assign idx       = bus.adr[RAM_ADDR_WIDTH-1:0];
    assign lane_mask = sel_to_mask(bus.sel);
    assign req       = bus.cyc && bus.stb;

    // Array update and optional clear
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            if (CLEAR_RAM_ON_RESET) begin
                for (int w = 0; w < RAM_DEPTH; w++) begin
                    mem[w] <= '0;
                end
            end
        end else if (req && bus.we) begin
            for (int lane = 0; lane < BUS_SEL_WIDTH; lane++) begin
                if (bus.sel[lane]) begin
                    mem[idx][lane*8 +: 8] <= bus.dat_w[lane*8 +: 8];   // Selected lane only
                end
            end
        end
    end

    // Response path
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req;                        // One pulse per strobe
            if (req && !bus.we) begin
                dat_q <= mem[idx] & lane_mask;   // Unselected lanes read zero
            end else begin
                dat_q <= '0;                     // Writes and idle return zero
            end
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = dat_q;
    assign bus.err   = 1'b0;   // Every RAM word is mapped

endmodule

//--- rtl/gpio_wb.sv
// General-purpose I/O registers on a Wishbone slave port, with output, input and toggle access
module gpio_wb
    import wb_soc_pkg::*;
(
    input  logic  clk_i,
    input  logic  RESET_MEM,    // Synchronous, active high
    input  gpio_t gpio_in_i,    // Asynchronous pins
    output gpio_t gpio_out_o,
    wb_if.slave   bus
);

    gpio_t     out_q;       // Output register
    gpio_t     in_meta;     // First synchronizer stage
    gpio_t     in_sync;     // Second stage, read through GPIO_REG_IN
    gpio_reg_t reg_sel;
    gpio_t     lane_mask;
    gpio_t     wr_bits;     // Written bits under sel
    bus_dat_t  rd_word;     // Unmasked read value
    logic      req;
    logic      ack_q;
    bus_dat_t  dat_q;

    assign reg_sel   = bus.adr[GPIO_REG_BITS-1:0];
    assign lane_mask = sel_to_mask(bus.sel);
    assign wr_bits   = bus.dat_w & lane_mask;
    assign req       = bus.cyc && bus.stb;

    // Two flops before the pins are seen by the bus
    always_ff @(posedge clk_i) begin
        in_meta <= gpio_in_i;
        in_sync <= in_meta;
    end

    // Output register, replace or toggle
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            out_q <= '0;
        end else if (req && bus.we) begin
            case (reg_sel)
                GPIO_REG_OUT:    out_q <= (out_q & ~lane_mask) | wr_bits;
                GPIO_REG_TOGGLE: out_q <= out_q ^ wr_bits;   // Flip written ones
                default:         out_q <= out_q;             // Input reg is read-only
            endcase
        end
    end

    // Register read mux
    always_comb begin
        case (reg_sel)
            GPIO_REG_OUT: rd_word = out_q;
            GPIO_REG_IN:  rd_word = in_sync;
            default:      rd_word = '0;   // Toggle reads back zero
        endcase
    end

    // Response path, one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req;
            dat_q <= (req && !bus.we) ? (rd_word & lane_mask) : '0;
        end
    end

    assign bus.ack    = ack_q;
    assign bus.dat_r  = dat_q;
    assign bus.err    = 1'b0;   // Unmapped index handled upstream
    assign gpio_out_o = out_q;

endmodule

//--- rtl/wb_decoder.sv
// Wishbone address decoder between the external master and the RAM and GPIO slaves
module wb_decoder
    import wb_soc_pkg::*;
(
    input  logic     clk_i,
    input  logic     RESET_MEM,   // Synchronous, active high
    input  logic     cyc_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  bus_sel_t sel_i,
    input  bus_adr_t adr_i,
    input  bus_dat_t dat_i,
    output bus_dat_t dat_o,
    output logic     ack_o,
    output logic     err_o,
    wb_if.master     ram_bus,
    wb_if.master     gpio_bus
);

    logic      req;
    logic      ram_hit;
    logic      gpio_hit;
    logic      gpio_page;   // Bits 8 to 2 all zero
    gpio_reg_t gpio_reg;
    logic      err_q;

    assign req       = cyc_i && stb_i;
    assign gpio_reg  = adr_i[GPIO_REG_BITS-1:0];
    assign gpio_page = (adr_i[REGION_BIT-1:GPIO_REG_BITS] == '0);

    // Region decode
    assign ram_hit  = !adr_i[REGION_BIT];
    assign gpio_hit = adr_i[REGION_BIT] && gpio_page
                      && (gpio_reg inside {GPIO_REG_OUT, GPIO_REG_IN, GPIO_REG_TOGGLE});

    // RAM request, strobe gated by decode
    assign ram_bus.cyc   = cyc_i;
    assign ram_bus.stb   = stb_i && ram_hit;
    assign ram_bus.we    = we_i;
    assign ram_bus.sel   = sel_i;
    assign ram_bus.adr   = adr_i;
    assign ram_bus.dat_w = dat_i;

    // GPIO request
    assign gpio_bus.cyc   = cyc_i;
    assign gpio_bus.stb   = stb_i && gpio_hit;
    assign gpio_bus.we    = we_i;
    assign gpio_bus.sel   = sel_i;
    assign gpio_bus.adr   = adr_i;
    assign gpio_bus.dat_w = dat_i;

    // Unmapped access answered with err after one cycle, same as a slave
    always_ff @(posedge clk_i) begin
        if (RESET_MEM) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req && !ram_hit && !gpio_hit;
        end
    end

    // Idle slaves return zero, so a plain OR merges the responses
    assign dat_o = ram_bus.dat_r | gpio_bus.dat_r;
    assign ack_o = ram_bus.ack | gpio_bus.ack;
    assign err_o = err_q | ram_bus.err | gpio_bus.err;

endmodule

//--- rtl/wb_soc_top.sv
// Top level of the Wishbone memory subsystem, one external master reaching RAM and GPIO
module wb_soc_top
    import wb_soc_pkg::*;
(
    input  logic     clk_i,
    input  logic     RESET_MEM,    // Synchronous, active high
    // Master request
    input  logic     cyc_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  bus_sel_t sel_i,
    input  bus_adr_t adr_i,
    input  bus_dat_t dat_i,
    // Response
    output bus_dat_t dat_o,
    output logic     ack_o,
    output logic     err_o,
    // Pins
    input  gpio_t    gpio_in_i,
    output gpio_t    gpio_out_o
);

    wb_if ram_bus ();    // Decoder to RAM
    wb_if gpio_bus ();   // Decoder to GPIO

    wb_decoder u_decoder (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .cyc_i     (cyc_i),
        .stb_i     (stb_i),
        .we_i      (we_i),
        .sel_i     (sel_i),
        .adr_i     (adr_i),
        .dat_i     (dat_i),
        .dat_o     (dat_o),
        .ack_o     (ack_o),
        .err_o     (err_o),
        .ram_bus   (ram_bus.master),
        .gpio_bus  (gpio_bus.master)
    );

    ram_wb u_ram (
        .clk_i     (clk_i),
        .RESET_MEM (RESET_MEM),
        .bus       (ram_bus.slave)
    );

    gpio_wb u_gpio (
        .clk_i      (clk_i),
        .RESET_MEM  (RESET_MEM),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .bus        (gpio_bus.slave)
    );

endmodule

//--- tb/wb_soc_assertions.sv
// Protocol checks on the top-level Wishbone ports, attached to the subsystem top with bind
module wb_soc_assertions
    import wb_soc_pkg::*;
(
    input logic     clk_i,
    input logic     RESET_MEM,
    input logic     cyc_i,
    input logic     stb_i,
    input logic     ack_o,
    input logic     err_o,
    input bus_dat_t dat_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int   assert_failures = 0;   // Read by the testbench at the end of the run
    logic rst_q = 1'b0;          // RESET_MEM seen on the previous edge

    always_ff @(posedge clk_i) begin
        rst_q <= RESET_MEM;
    end

    // A slave answers with ack or err, never both
    one_response: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        !(ack_o && err_o))
        else begin
            assert_failures += 1;
            $error("ack_o and err_o high in the same cycle");
        end

    // One-cycle latency, so a request must sit on the edge before
    resp_after_req: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        (ack_o || err_o) |-> $past(cyc_i && stb_i))
        else begin
            assert_failures += 1;
            $error("response without a request on the previous edge");
        end

    // Requests during reset are dropped
    quiet_in_reset: assert property (@(posedge clk_i)
        rst_q |-> (!ack_o && !err_o))
        else begin
            assert_failures += 1;
            $error("response seen while RESET_MEM was high");
        end

    // Idle and error cycles carry zero data
    data_idle_zero: assert property (@(posedge clk_i) disable iff (RESET_MEM)
        !ack_o |-> (dat_o == '0))
        else begin
            assert_failures += 1;
            $error("dat_o nonzero without ack_o");
        end

endmodule

bind wb_soc_top wb_soc_assertions u_assert (
    .clk_i     (clk_i),
    .RESET_MEM (RESET_MEM),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .ack_o     (ack_o),
    .err_o     (err_o),
    .dat_o     (dat_o)
);

//--- tb/tb_wb_soc.sv
// Self-checking testbench that acts as the bus master of the memory subsystem, simulation top
module tb_wb_soc
    import wb_soc_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic     clk_i = 1'b0;
    logic     RESET_MEM;
    logic     cyc_i;
    logic     stb_i;
    logic     we_i;
    bus_sel_t sel_i;
    bus_adr_t adr_i;
    bus_dat_t dat_i;
    gpio_t    gpio_in_i;
    bus_dat_t dat_o;
    logic     ack_o;
    logic     err_o;
    gpio_t    gpio_out_o;

    bus_dat_t    shadow_ram [RAM_DEPTH];   // Expected RAM contents
    gpio_t       shadow_out;               // Expected output register
    gpio_t       shadow_in;                // Pin value settled in the synchronizer
    logic [31:0] rng = 32'h4d7c;

    wb_soc_top uut (
        .clk_i      (clk_i),
        .RESET_MEM  (RESET_MEM),
        .cyc_i      (cyc_i),
        .stb_i      (stb_i),
        .we_i       (we_i),
        .sel_i      (sel_i),
        .adr_i      (adr_i),
        .dat_i      (dat_i),
        .dat_o      (dat_o),
        .ack_o      (ack_o),
        .err_o      (err_o),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

    always #20 clk_i = ~clk_i;   // 40 ns period

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Byte enables spread over the data bits
    function automatic bus_dat_t lane_bits(input bus_sel_t sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    function automatic bus_adr_t gpio_addr(input gpio_reg_t r);
        return {1'b1, {(BUS_ADDR_WIDTH-1-GPIO_REG_BITS){1'b0}}, r};
    endfunction

    // Bus error prediction from the address map
    function automatic logic is_unmapped(input bus_adr_t adr);
        logic miss;
        if (!adr[BUS_ADDR_WIDTH-1]) begin
            miss = 1'b0;                                   // RAM region
        end else if (adr[BUS_ADDR_WIDTH-2:GPIO_REG_BITS] != '0) begin
            miss = 1'b1;                                   // Outside the GPIO page
        end else begin
            miss = (adr[GPIO_REG_BITS-1:0] == 2'd3);
        end
        return miss;
    endfunction

    function automatic bus_dat_t expect_read(input bus_adr_t adr, input bus_sel_t sel);
        bus_dat_t word;
        if (is_unmapped(adr)) begin
            word = '0;
        end else if (!adr[BUS_ADDR_WIDTH-1]) begin
            word = shadow_ram[adr[RAM_ADDR_WIDTH-1:0]];
        end else begin
            case (adr[GPIO_REG_BITS-1:0])
                GPIO_REG_OUT: word = shadow_out;
                GPIO_REG_IN:  word = shadow_in;
                default:      word = '0;   // Toggle reads zero
            endcase
        end
        return word & lane_bits(sel);
    endfunction

    task automatic check_data(input string name, input bus_dat_t exp, input bus_dat_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // One request, then wait for ack or err
    task automatic transfer(input string name, input logic we, input bus_adr_t adr,
                            input bus_sel_t sel, input bus_dat_t wdat,
                            output bus_dat_t rdat);
        int   waited;
        logic seen;
        @(negedge clk_i);
        cyc_i  = 1'b1;
        stb_i  = 1'b1;
        we_i   = we;
        adr_i  = adr;
        sel_i  = sel;
        dat_i  = wdat;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 8) begin
            @(negedge clk_i);
            waited++;
            seen = ack_o || err_o;
            if (waited == 1) begin
                cyc_i = 1'b0;   // Strobe lasts one cycle
                stb_i = 1'b0;
                we_i  = 1'b0;
            end
        end
        if (!seen) begin
            $display("%s: no ack or err within 8 cycles of the request", name);
            $display("TEST FAIL");
            $fatal(1);
        end
        if (waited != 1) begin
            $display("%s: response came after %0d cycles instead of one", name, waited);
            $display("TEST FAIL");
            $fatal(1);
        end
        check_resp({name, " err"}, is_unmapped(adr), err_o);
        check_resp({name, " ack"}, !is_unmapped(adr), ack_o);
        rdat = dat_o;
    endtask

    task automatic bus_write(input string name, input bus_adr_t adr, input bus_sel_t sel,
                             input bus_dat_t dat);
        bus_dat_t rdat;
        bus_dat_t m;
        m = lane_bits(sel);
        transfer(name, 1'b1, adr, sel, dat, rdat);
        check_data({name, " dat_o"}, '0, rdat);   // Writes return no data
        if (!adr[BUS_ADDR_WIDTH-1]) begin
            shadow_ram[adr[RAM_ADDR_WIDTH-1:0]] =
                (shadow_ram[adr[RAM_ADDR_WIDTH-1:0]] & ~m) | (dat & m);
        end else if (!is_unmapped(adr)) begin
            if (adr[GPIO_REG_BITS-1:0] == GPIO_REG_OUT) begin
                shadow_out = (shadow_out & ~m) | (dat & m);
            end else if (adr[GPIO_REG_BITS-1:0] == GPIO_REG_TOGGLE) begin
                shadow_out = shadow_out ^ (dat & m);
            end
        end
    endtask

    task automatic bus_read(input string name, input bus_adr_t adr, input bus_sel_t sel);
        bus_dat_t rdat;
        transfer(name, 1'b0, adr, sel, '0, rdat);
        check_data(name, expect_read(adr, sel), rdat);
    endtask

    initial begin
        bus_adr_t a;
        bus_sel_t s;
        for (int w = 0; w < RAM_DEPTH; w++) begin
            shadow_ram[w] = '0;
        end
        shadow_out = '0;
        shadow_in  = '0;
        gpio_in_i  = '0;
        // Write request held through reset is dropped by the DUT
        RESET_MEM = 1'b1;
        cyc_i     = 1'b1;
        stb_i     = 1'b1;
        we_i      = 1'b1;
        sel_i     = 4'hf;
        adr_i     = 10'd5;
        dat_i     = 32'hffff_ffff;
        for (int c = 0; c < 2; c++) begin
            @(negedge clk_i);
            check_resp("reset ack", 1'b0, ack_o);
            check_resp("reset err", 1'b0, err_o);
        end
        RESET_MEM = 1'b0;
        cyc_i     = 1'b0;
        stb_i     = 1'b0;
        we_i      = 1'b0;
        dat_i     = '0;
        check_data("reset dat_o", '0, dat_o);
        check_gpio("reset gpio_out", '0, gpio_out_o);
        for (int i = 0; i < 8; i++) begin
            bus_read("reset ram", bus_adr_t'(i), 4'hf);
        end
        bus_read("reset ram top", 10'h0ff, 4'hf);

        // Random RAM traffic on 32 words, bit 8 aliases
        for (int n = 0; n < 96; n++) begin
            rng = xorshift(rng);
            a   = {1'b0, rng[8], rng[7], 3'd0, rng[3:0]};
            s   = rng[12:9];
            if (rng[13]) begin
                rng = xorshift(rng);
                bus_write("ram rand write", a, s, rng);
            end else begin
                bus_read("ram rand read", a, s);
            end
        end

        // Single-byte writes over a full word
        rng = xorshift(rng);
        bus_write("partial fill", 10'd40, 4'hf, rng);
        for (int lane = 0; lane < BUS_SEL_WIDTH; lane++) begin
            rng = xorshift(rng);
            s   = 4'b0001 << lane;
            bus_write("partial byte", 10'd40, s, rng);
            bus_read("partial check", 10'd40, 4'hf);
        end

        for (int n = 0; n < 8; n++) begin
            rng = xorshift(rng);
            s   = rng[3:0];
            rng = xorshift(rng);
            bus_write("gpio out", gpio_addr(GPIO_REG_OUT), s, rng);
            check_gpio("gpio out pins", shadow_out, gpio_out_o);
            bus_read("gpio out read", gpio_addr(GPIO_REG_OUT), 4'hf);
        end
        for (int n = 0; n < 8; n++) begin
            rng = xorshift(rng);
            s   = rng[3:0];
            rng = xorshift(rng);
            bus_write("gpio toggle", gpio_addr(GPIO_REG_TOGGLE), s, rng);
            check_gpio("gpio toggle pins", shadow_out, gpio_out_o);
            bus_read("gpio toggle read", gpio_addr(GPIO_REG_TOGGLE), 4'hf);
        end

        // Three cycles give the two-flop synchronizer one cycle of margin
        for (int n = 0; n < 8; n++) begin
            rng       = xorshift(rng);
            gpio_in_i = rng;
            repeat (3) @(negedge clk_i);
            shadow_in = gpio_in_i;
            rng       = xorshift(rng);
            bus_read("gpio in", gpio_addr(GPIO_REG_IN), rng[3:0]);
            bus_write("gpio in write", gpio_addr(GPIO_REG_IN), 4'hf, ~shadow_in);
            check_gpio("gpio in write pins", shadow_out, gpio_out_o);
            bus_read("gpio in after write", gpio_addr(GPIO_REG_IN), 4'hf);
        end

        rng = xorshift(rng);
        bus_write("unmapped reg3", gpio_addr(2'd3), 4'hf, rng);
        bus_read("unmapped reg3 read", gpio_addr(2'd3), 4'hf);
        for (int n = 0; n < 16; n++) begin
            rng = xorshift(rng);
            a   = {1'b1, rng[8:0]};
            if (a[BUS_ADDR_WIDTH-2:GPIO_REG_BITS] == '0) begin
                a[GPIO_REG_BITS] = 1'b1;   // Force off the GPIO page
            end
            rng = xorshift(rng);
            bus_write("unmapped write", a, 4'hf, rng);
            bus_read("unmapped read", a, 4'hf);
            bus_read("ram after unmapped", {2'b00, a[RAM_ADDR_WIDTH-1:0]}, 4'hf);
            check_gpio("gpio after unmapped", shadow_out, gpio_out_o);
        end

        if (uut.u_assert.assert_failures != 0) begin
            $display("%0d protocol assertions failed", uut.u_assert.assert_failures);
            $display("TEST FAIL");
            $fatal(1);
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- vlog.f
rtl/wb_soc_pkg.sv
rtl/wb_if.sv
rtl/ram_wb.sv
rtl/gpio_wb.sv
rtl/wb_decoder.sv
rtl/wb_soc_top.sv
tb/wb_soc_assertions.sv
tb/tb_wb_soc.sv

//--- Makefile
# Verilator build and run of the Wishbone memory subsystem testbench

BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_wb_soc \
		-f vlog.f -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/Vtb_wb_soc

clean:
	rm -rf $(BUILD_DIR)
